// File: source/graphPkg.sv
package graphPkg;

    // 7-cube, one bit per vertex.
    localparam int DIMENSIONS = 7;
    localparam int GRAPH_BITS = 1 << DIMENSIONS;

    typedef logic [GRAPH_BITS-1:0] graphT;

    // every vertex that sits one bit flip away from some vertex of the set.
    function automatic graphT neighborMask(input graphT vertices);
        graphT result;
        result = '0;
        for (int d = 0; d < DIMENSIONS; d++) begin
            for (int v = 0; v < GRAPH_BITS; v++) begin
                result[v ^ (1 << d)] |= vertices[v];
            end
        end
        return result;
    endfunction

endpackage

// File: source/pcoeffPkg.sv
package pcoeffPkg;

    // an independent set of the 7-cube has at most 64 vertices,
    // so components plus singletons never exceed 64.
    localparam int COUNT_WIDTH = 7;

    typedef logic [COUNT_WIDTH-1:0] countT;

    localparam int PCOEFF_BITS = 65; // holds 2**64.

    typedef logic [PCOEFF_BITS-1:0] pcoeffT;

endpackage

// File: source/graphStreamIf.sv
`timescale 1ns/1ps

// one graph item on its way to the component counter.
interface graphItemIf;
    import graphPkg::*;
    import pcoeffPkg::*;

    logic valid; // one-cycle strobe per item.
    graphT graph;
    logic last;
    countT singletonCount;

    modport source (
        output valid,
        output graph,
        output last,
        output singletonCount
    );

    modport sink (
        input valid,
        input graph,
        input last,
        input singletonCount
    );
endinterface

// finished component count, with the item's side data.
interface componentResultIf;
    import pcoeffPkg::*;

    logic valid;
    countT componentCount;
    logic last;
    countT singletonCount;

    modport source (
        output valid,
        output componentCount,
        output last,
        output singletonCount
    );

    modport sink (
        input valid,
        input componentCount,
        input last,
        input singletonCount
    );
endinterface

// File: source/leafElimination.sv
`timescale 1ns/1ps

module leafElimination (
    input graphPkg::graphT graphIn,
    output graphPkg::graphT graphOut
);
    import graphPkg::*;

    graphT leaves;

    // a leaf hangs below its only neighbor. that neighbor then has a higher
    // neighbor itself, so it is never removed in the same pass.
    always_comb begin
        logic [2:0] lowerCount;
        logic [2:0] upperCount;
        leaves = '0;
        lowerCount = '0;
        upperCount = '0;
        for (int v = 0; v < GRAPH_BITS; v++) begin
            lowerCount = '0;
            upperCount = '0;
            for (int d = 0; d < DIMENSIONS; d++) begin
                if (graphIn[v ^ (1 << d)]) begin
                    if (((v >> d) & 1) == 1) begin
                        lowerCount = lowerCount + 3'd1; // neighbor has bit d cleared.
                    end else begin
                        upperCount = upperCount + 3'd1;
                    end
                end
            end
            leaves[v] = graphIn[v] && (lowerCount == 3'd1) && (upperCount == 3'd0);
        end
    end

    assign graphOut = graphIn & ~leaves;

endmodule

// File: source/singletonElimination.sv
`timescale 1ns/1ps

module singletonElimination (
    input logic clk,
    input logic reset,
    input graphPkg::graphT graphIn,
    input logic validIn,
    input logic lastIn,
    graphItemIf.source out
);
    import graphPkg::*;
    import pcoeffPkg::*;

    graphT isolated;
    countT isolatedCount;

    assign isolated = graphIn & ~neighborMask(graphIn); // no set neighbor at all.

    always_comb begin
        isolatedCount = '0;
        for (int v = 0; v < GRAPH_BITS; v++) begin
            isolatedCount = isolatedCount + countT'(isolated[v]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= validIn;
        end
    end

    always_ff @(posedge clk) begin
        out.graph <= graphIn & ~isolated;
        out.singletonCount <= isolatedCount;
        out.last <= lastIn;
    end

endmodule

// File: source/graphFifo.sv
`timescale 1ns/1ps

module graphFifo #(
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic reset,
    graphItemIf.sink in,
    graphItemIf.source out,
    input logic pop,
    output logic almostFull
);
    import graphPkg::*;
    import pcoeffPkg::*;

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    localparam logic [PTR_BITS:0] FULL_LEVEL = (PTR_BITS + 1)'(FIFO_DEPTH);
    localparam logic [PTR_BITS:0] ALMOST_FULL_LEVEL = (PTR_BITS + 1)'(FIFO_DEPTH - 3);

    graphT graphMem [FIFO_DEPTH];
    logic lastMem [FIFO_DEPTH];
    countT singletonMem [FIFO_DEPTH];

    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS:0] occupancy;
    logic full;
    logic empty;
    logic doWrite;
    logic doPop;

    assign full = (occupancy == FULL_LEVEL);
    assign empty = (occupancy == '0);
    assign doWrite = in.valid && !full;
    assign doPop = pop && !empty;
    assign almostFull = (occupancy >= ALMOST_FULL_LEVEL); // room for the input stages.

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1; // depth is a power of two, pointers wrap.
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doWrite, doPop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            graphMem[wrPtr] <= in.graph;
            lastMem[wrPtr] <= in.last;
            singletonMem[wrPtr] <= in.singletonCount;
        end
    end

    // head is visible without a read cycle.
    assign out.valid = !empty;
    assign out.graph = graphMem[rdPtr];
    assign out.last = lastMem[rdPtr];
    assign out.singletonCount = singletonMem[rdPtr];

endmodule

// File: source/componentCounter.sv
`timescale 1ns/1ps

module componentCounter (
    input logic clk,
    input logic reset,
    input logic freezeCore,
    graphItemIf.sink in,
    input logic load,
    output logic idle,
    componentResultIf.source result
);
    import graphPkg::*;
    import pcoeffPkg::*;

    logic busy;
    logic resultValid;
    logic doLoad;
    logic advance;
    graphT remaining; // vertices not yet assigned to a component.
    graphT region; // component being flooded.
    graphT grown;
    graphT leftover;
    countT components;
    countT singletons;
    logic lastFlag;

    assign doLoad = !busy && load && in.valid;
    assign advance = busy && !freezeCore;

    // one flood step, kept inside the remaining set.
    assign grown = (region | neighborMask(region)) & remaining;
    assign leftover = remaining & ~region;

    assign idle = !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (doLoad) begin
                busy <= 1'b1;
            end else if (advance && (remaining == '0)) begin
                busy <= 1'b0;
                resultValid <= 1'b1; // single-cycle strobe.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doLoad) begin
            remaining <= in.graph;
            region <= in.graph & (~in.graph + 1'b1); // seed with the lowest vertex.
            components <= '0;
            singletons <= in.singletonCount;
            lastFlag <= in.last;
        end else if (advance && (remaining != '0)) begin
            if (grown == region) begin
                // region is closed, retire it and reseed.
                remaining <= leftover;
                region <= leftover & (~leftover + 1'b1);
                components <= components + 1'b1;
            end else begin
                region <= grown;
            end
        end
    end

    assign result.valid = resultValid;
    assign result.componentCount = components;
    assign result.last = lastFlag;
    assign result.singletonCount = singletons;

endmodule

// File: source/aggregatingPipeline.sv
`timescale 1ns/1ps

module aggregatingPipeline #(
    parameter int ITEM_COUNT_BITS = 16,
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic reset,
    input logic accumulatorClear,
    input logic botValid,
    input graphPkg::graphT bot,
    input graphPkg::graphT sharedTop,
    input logic lastBotOfBatch,
    input logic freezeCore,
    output logic almostFull,
    output logic batchValid,
    output logic [ITEM_COUNT_BITS+pcoeffPkg::PCOEFF_BITS-1:0] pcoeffSum,
    output logic [ITEM_COUNT_BITS-1:0] pcoeffCount
);
    import graphPkg::*;
    import pcoeffPkg::*;

    localparam int SUM_BITS = ITEM_COUNT_BITS + PCOEFF_BITS;

    graphT graphD;
    logic validD;
    logic lastD;
    graphT leafGraph;
    graphT leafGraphDD;
    logic validDD;
    logic lastDD;

    logic counterIdle;
    logic pop;

    logic [COUNT_WIDTH:0] exponent;
    pcoeffT pcoeff;
    logic [SUM_BITS-1:0] pcoeffWide;
    logic [SUM_BITS-1:0] sumAcc;
    logic [ITEM_COUNT_BITS-1:0] countAcc;

    graphItemIf stagedItem ();
    graphItemIf headItem ();
    componentResultIf componentResult ();

    always_ff @(posedge clk) begin
        graphD <= sharedTop & ~bot;
        lastD <= lastBotOfBatch;
        leafGraphDD <= leafGraph;
        lastDD <= lastD;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
            validDD <= 1'b0;
        end else begin
            validD <= botValid;
            validDD <= validD;
        end
    end

    leafElimination leafStage (.graphIn(graphD), .graphOut(leafGraph));

    singletonElimination singletonStage (
        .clk(clk),
        .reset(reset),
        .graphIn(leafGraphDD),
        .validIn(validDD),
        .lastIn(lastDD),
        .out(stagedItem.source)
    );

    graphFifo #(.FIFO_DEPTH(FIFO_DEPTH)) itemFifo (
        .clk(clk),
        .reset(reset),
        .in(stagedItem.sink),
        .out(headItem.source),
        .pop(pop),
        .almostFull(almostFull)
    );

    assign pop = counterIdle && !freezeCore; // fifo ignores pop while empty.

    componentCounter counter (
        .clk(clk),
        .reset(reset),
        .freezeCore(freezeCore),
        .in(headItem.sink),
        .load(pop),
        .idle(counterIdle),
        .result(componentResult.source)
    );

    // coefficient is 2**(components + singletons).
    assign exponent = componentResult.componentCount + componentResult.singletonCount;
    assign pcoeff = pcoeffT'(1) << exponent;
    assign pcoeffWide = {{ITEM_COUNT_BITS{1'b0}}, pcoeff};

    always_ff @(posedge clk) begin
        if (reset) begin
            sumAcc <= '0;
            countAcc <= '0;
            batchValid <= 1'b0;
        end else begin
            batchValid <= componentResult.valid && componentResult.last;
            if (accumulatorClear || (componentResult.valid && componentResult.last)) begin
                sumAcc <= '0; // fresh batch.
                countAcc <= '0;
            end else if (componentResult.valid) begin
                sumAcc <= sumAcc + pcoeffWide;
                countAcc <= countAcc + 1'b1;
            end
        end
    end

    // batch totals include the closing item.
    always_ff @(posedge clk) begin
        if (componentResult.valid && componentResult.last) begin
            pcoeffSum <= sumAcc + pcoeffWide;
            pcoeffCount <= countAcc + 1'b1;
        end
    end

endmodule

// File: bench/aggregatingPipeline_chk.sv
`timescale 1ns/1ps

module aggregatingPipeline_chk #(
    parameter int PTR_BITS = 1
) (
    input logic clk,
    input logic reset,
    input logic fifoWrite,
    input logic fifoFull,
    input logic fifoEmpty,
    input logic [PTR_BITS-1:0] readPtr,
    input logic batchValid,
    input logic almostFull
);

    int assertFailures = 0;

    writeWhenFull: assert property (@(posedge clk) disable iff (reset) !(fifoWrite && fifoFull))
        else begin
            $error("item written while the fifo is full.");
            assertFailures++;
        end

    // an empty fifo without a write keeps its head where it is.
    popWhenEmpty: assert property (@(posedge clk) disable iff (reset)
        (fifoEmpty && !fifoWrite) |=> (fifoEmpty && $stable(readPtr)))
        else begin
            $error("item popped while the fifo is empty.");
            assertFailures++;
        end

    // covers the reset cycles and the first cycle after release.
    batchInReset: assert property (@(posedge clk) (reset || $past(reset)) |=> !batchValid)
        else begin
            $error("batchValid high during or right after reset.");
            assertFailures++;
        end

    almostFullInReset: assert property (@(posedge clk) reset |=> !almostFull)
        else begin
            $error("almostFull high after reset.");
            assertFailures++;
        end

endmodule

bind graphFifo aggregatingPipeline_chk #(.PTR_BITS(PTR_BITS)) fifoChk (
    .clk(clk),
    .reset(reset),
    .fifoWrite(in.valid),
    .fifoFull(full),
    .fifoEmpty(empty),
    .readPtr(rdPtr),
    .batchValid(1'b0),
    .almostFull(almostFull)
);

bind aggregatingPipeline aggregatingPipeline_chk topChk (
    .clk(clk),
    .reset(reset),
    .fifoWrite(1'b0),
    .fifoFull(1'b0),
    .fifoEmpty(1'b0),
    .readPtr(1'b0),
    .batchValid(batchValid),
    .almostFull(almostFull)
);

// File: bench/aggregatingPipelineTb.sv
`timescale 1ns/1ps

module aggregatingPipelineTb;
    import graphPkg::*;
    import pcoeffPkg::*;

    localparam int ITEM_COUNT_BITS = 16;
    localparam int SUM_BITS = ITEM_COUNT_BITS + PCOEFF_BITS;
    localparam int PLANNED_ITEMS = 480; // upper bound over all tests.
    localparam int TIMEOUT_CYCLES = PLANNED_ITEMS * 300 + 1000;

    typedef logic [SUM_BITS-1:0] sumT;
    typedef logic [ITEM_COUNT_BITS-1:0] itemCountT;

    logic clk;
    logic reset;
    logic accumulatorClear;
    logic botValid;
    graphT bot;
    graphT sharedTop;
    logic lastBotOfBatch;
    logic freezeCore;
    logic almostFull;
    logic batchValid;
    sumT pcoeffSum;
    itemCountT pcoeffCount;

    sumT expectedSums[$];
    itemCountT expectedCounts[$];
    sumT partialSum;
    itemCountT partialCount;
    logic freezeRandom;
    int cycleCount;
    int sumErrors = 0;
    int countErrors = 0;
    int otherErrors = 0;
    int assertErrors = 0;

    aggregatingPipeline UUT (
        .clk(clk),
        .reset(reset),
        .accumulatorClear(accumulatorClear),
        .botValid(botValid),
        .bot(bot),
        .sharedTop(sharedTop),
        .lastBotOfBatch(lastBotOfBatch),
        .freezeCore(freezeCore),
        .almostFull(almostFull),
        .batchValid(batchValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // plain flood over hypercube neighbors, isolated vertices count as components.
    function automatic int countComponents(input graphT g);
        graphT seen;
        int frontier[$];
        int v;
        int u;
        int n;
        seen = '0;
        n = 0;
        for (int s = 0; s < GRAPH_BITS; s++) begin
            if (g[s] && !seen[s]) begin
                n++;
                seen[s] = 1'b1;
                frontier.push_back(s);
                while (frontier.size() > 0) begin
                    v = frontier.pop_front();
                    for (int d = 0; d < DIMENSIONS; d++) begin
                        u = v ^ (1 << d);
                        if (g[u] && !seen[u]) begin
                            seen[u] = 1'b1;
                            frontier.push_back(u);
                        end
                    end
                end
            end
        end
        return n;
    endfunction

    function automatic graphT randomGraph();
        graphT a;
        graphT b;
        a = {$urandom(), $urandom(), $urandom(), $urandom()};
        b = {$urandom(), $urandom(), $urandom(), $urandom()};
        case ($urandom_range(0, 3))
            0: return a & b;
            1: return a;
            2: return a | b;
            default: return '0;
        endcase
    endfunction

    function automatic graphT directedGraph(input int kind);
        graphT g;
        g = '0;
        for (int v = 0; v < GRAPH_BITS; v++) begin
            case (kind)
                0: g[v] = ~^v[DIMENSIONS-1:0]; // even weight, all isolated.
                1: g[v] = ~^v[DIMENSIONS-1:1]; // pairs along dimension 0.
                default: g[v] = (v == 96) || (v == 100) || (v == 108);
            endcase
        end
        if (kind == 2) begin
            for (int k = 0; k <= DIMENSIONS; k++) begin
                g[(1 << k) - 1] = 1'b1; // chain 0, 1, 3, 7 ... 127.
            end
        end
        return g;
    endfunction

    task automatic checkSum(input sumT actual, input sumT expected);
        if (actual !== expected) begin
            sumErrors++;
            $display("Error at %0t: pcoeffSum is %0h, expected %0h", $time, actual, expected);
        end
    endtask

    task automatic checkCount(input itemCountT actual, input itemCountT expected);
        if (actual !== expected) begin
            countErrors++;
            $display("Error at %0t: pcoeffCount is %0d, expected %0d", $time, actual, expected);
        end
    endtask

    task automatic nextCycle();
        @(negedge clk);
        botValid = 1'b0;
        lastBotOfBatch = 1'b0;
        freezeCore = freezeRandom ? 1'($urandom_range(0, 1)) : 1'b0;
    endtask

    task automatic sendItem(input graphT top, input graphT mask, input logic last);
        nextCycle();
        while (almostFull) begin
            nextCycle();
        end
        sharedTop = top;
        bot = mask;
        lastBotOfBatch = last;
        botValid = 1'b1;
        partialSum = partialSum + (sumT'(1) << countComponents(top & ~mask));
        partialCount = partialCount + 1'b1;
        if (last) begin
            expectedSums.push_back(partialSum);
            expectedCounts.push_back(partialCount);
            partialSum = '0;
            partialCount = '0;
        end
    endtask

    task automatic sendRandomBatch(input int length);
        for (int i = 0; i < length; i++) begin
            sendItem(randomGraph(), randomGraph(), i == length - 1);
        end
    endtask

    task automatic waitBatches();
        while (expectedSums.size() != 0) begin
            nextCycle();
        end
    endtask

    always @(negedge clk) begin
        if (!reset && batchValid === 1'b1) begin
            if (expectedSums.size() == 0) begin
                otherErrors++;
                $display("Error at %0t: a batch was reported but none was expected", $time);
            end else begin
                checkSum(pcoeffSum, expectedSums.pop_front());
                checkCount(pcoeffCount, expectedCounts.pop_front());
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(43));
        reset = 1'b1;
        accumulatorClear = 1'b0;
        botValid = 1'b0;
        bot = '0;
        sharedTop = '0;
        lastBotOfBatch = 1'b0;
        freezeCore = 1'b0;
        freezeRandom = 1'b0;
        partialSum = '0;
        partialCount = '0;
        repeat (2) nextCycle();
        reset = 1'b0;

        repeat (6) begin
            nextCycle();
            if (batchValid !== 1'b0 || almostFull !== 1'b0) begin
                otherErrors++;
                $display("Error at %0t: batchValid or almostFull is not low after reset",
                    $time);
            end
        end

        repeat (40) sendRandomBatch(1);
        waitBatches();
        repeat (20) sendRandomBatch($urandom_range(1, 12));
        waitBatches();

        sendItem('0, '0, 1'b1);
        sendItem('1, '0, 1'b1);
        sendItem(directedGraph(0), '0, 1'b1);
        sendItem(directedGraph(1), '0, 1'b1);
        sendItem('1, ~directedGraph(2), 1'b1); // chains carved out of the full cube.
        waitBatches();

        freezeRandom = 1'b1;
        repeat (15) sendRandomBatch($urandom_range(1, 12));
        waitBatches();
        freezeRandom = 1'b0;

        // partial batch, dropped by the clear once fully absorbed.
        repeat (3) sendItem(randomGraph(), randomGraph(), 1'b0);
        while (UUT.countAcc != 3) begin
            nextCycle();
        end
        nextCycle();
        accumulatorClear = 1'b1;
        partialSum = '0;
        partialCount = '0;
        nextCycle();
        accumulatorClear = 1'b0;
        sendRandomBatch(2);
        waitBatches();
        repeat (4) nextCycle();

        assertErrors = UUT.topChk.assertFailures + UUT.itemFifo.fifoChk.assertFailures;
        $display("Errors: %0d sum, %0d count, %0d other, %0d assertion",
            sumErrors, countErrors, otherErrors, assertErrors);
        if (sumErrors == 0 && countErrors == 0 && otherErrors == 0 && assertErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/graphPkg.sv
source/pcoeffPkg.sv
source/graphStreamIf.sv
source/leafElimination.sv
source/singletonElimination.sv
source/graphFifo.sv
source/componentCounter.sv
source/aggregatingPipeline.sv
bench/aggregatingPipeline_chk.sv
bench/aggregatingPipelineTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module aggregatingPipelineTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
